/* files.f */
rtl/mpi_pkg.sv
rtl/link_if.sv
rtl/comm_table.sv
rtl/reduce_unit.sv
rtl/node.sv
rtl/network.sv
tb/network_assert.sv
tb/network_tb.sv

/* run.sh */
#!/bin/sh
# Build the network testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module network_tb \
	-Mdir obj_dir -o Vnetwork_tb \
	-f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vnetwork_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	echo "Failures found in $LOG"
	exit 1
fi

echo "No failures found in $LOG"
exit 0

/* tb/network_stim.txt */
# test opcode ctx0 ctx1 ctx2 ctx3 skew0..3 data0..3 resmask err exp0..3, hex, nodes 0_0_0 0_0_1 0_1_0 1_0_0
# skew ff is drawn from the LFSR, resmask bit n marks node n as delivering, opcode 0 only watches a reset
reset_idle 0 11 11 11 11 0 0 0 0 0 0 0 0 0 0 0 0 0 0
allreduce_basic e 11 11 11 11 0 0 0 0 1 2 3 4 f 0 a a a a
allreduce_wrap e 22 22 22 22 0 0 0 0 ffffffff 80000000 80000000 5 f 0 4 4 4 4
reduce_basic c 31 31 31 31 0 0 0 0 10 20 30 40 1 0 a0 0 0 0
reduce_large c 32 32 32 32 0 0 0 0 12345678 11111111 22222222 33333333 1 0 789abcde 0 0 0
bcast_basic 7 40 40 40 40 0 0 0 0 deadbeef 1 2 3 f 0 deadbeef deadbeef deadbeef deadbeef
bcast_skew 7 41 41 41 41 0 3 1 2 cafef00d aaaaaaaa bbbbbbbb cccccccc f 0 cafef00d cafef00d cafef00d cafef00d
allreduce_skew_fixed e 50 50 50 50 3 0 2 1 7 8 9 a f 0 22 22 22 22
allreduce_skew_rand_a e 51 51 51 51 ff ff ff ff 100 200 300 400 f 0 a00 a00 a00 a00
allreduce_skew_rand_b e 52 52 52 52 ff ff ff ff 0badf00d 11 22 33 f 0 0badf073 0badf073 0badf073 0badf073
reduce_skew_rand c 53 53 53 53 ff ff ff ff 5 6 7 8 1 0 1a 0 0 0
ctx_err_allreduce e 11 55 11 11 0 0 0 0 1 2 3 4 0 1 0 0 0 0
ctx_err_reduce c 33 33 33 9a 1 0 2 0 5 6 7 8 0 1 0 0 0 0
reset_idle_again 0 60 60 60 60 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* tb/network_tb.sv */
`timescale 1ns/100ps

module network_tb;
	import mpi_pkg::*;

	localparam int DATA_W = 32;
	localparam int n_node = 4;
	localparam int reset_cycles = 16;
	localparam int settle_cycles = 3;
	localparam int result_timeout = 40;
	localparam int quiet_cycles = 20;
	localparam string stim_path = "tb/network_stim.txt";

	logic clk;
	logic rst_n;
	// Node order 0_0_0 hub, then 0_0_1, 0_1_0, 1_0_0
	logic [comm_w-1:0] newcomm [n_node];
	logic [flit_w-1:0] reduce_me [n_node];
	logic [DATA_W-1:0] result [n_node];
	logic result_valid [n_node];
	logic ctx_err;

	// Current test line
	string test_name;
	logic [op_w-1:0] t_op;
	logic [ctx_w-1:0] t_ctx [n_node];
	logic [7:0] t_skew [n_node];
	logic [DATA_W-1:0] t_data [n_node];
	logic [3:0] t_mask;
	logic [3:0] t_err;
	logic [DATA_W-1:0] t_exp [n_node];

	logic [31:0] lfsr;
	logic [seq_w-1:0] seq;
	int test_errs;
	int n_run;
	int n_pass;
	int n_fail;

	always #5 clk = ~clk;

	network #(
		.DATA_W(DATA_W)
	) network_inst (
		.clk(clk),
		.rst_n(rst_n),
		.newcomm_0_0_0(newcomm[0]),
		.newcomm_0_0_1(newcomm[1]),
		.newcomm_0_1_0(newcomm[2]),
		.newcomm_1_0_0(newcomm[3]),
		.reduce_me_0_0_0(reduce_me[0]),
		.reduce_me_0_0_1(reduce_me[1]),
		.reduce_me_0_1_0(reduce_me[2]),
		.reduce_me_1_0_0(reduce_me[3]),
		.result_0_0_0(result[0]),
		.result_0_0_1(result[1]),
		.result_0_1_0(result[2]),
		.result_1_0_0(result[3]),
		.result_valid_0_0_0(result_valid[0]),
		.result_valid_0_0_1(result_valid[1]),
		.result_valid_0_1_0(result_valid[2]),
		.result_valid_1_0_0(result_valid[3]),
		.ctx_err(ctx_err)
	);

	// Same properties on every node, hub and leaves
	bind node network_assert network_assert_inst (
		.clk(clk),
		.rst_n(rst_n),
		.result_valid(result_valid),
		.ctx_err(ctx_err),
		.link_valid({q_valid[3], q_valid[2], q_valid[1], q_valid[0]})
	);

	////////////////////////////////////////////////////////////////////////////
	// Word builders and helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// Skew of 0 to 3, one LFSR step per bit
	task automatic draw_skew(output logic [7:0] skew);
		logic [1:0] b;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
		skew = {6'd0, b};
	endtask

	function automatic string node_name(input int n);
		case (n)
			0: return "0_0_0";
			1: return "0_0_1";
			2: return "0_1_0";
			default: return "1_0_0";
		endcase
	endfunction

	// Fixed tree, hub is root over x y z, leaves point up
	function automatic logic [comm_w-1:0] make_comm(input logic [ctx_w-1:0] ctx, input int n);
		logic [comm_w-1:0] w;
		w = '0;
		w[comm_valid_bit] = 1'b1;
		w[comm_ctx_lsb +: ctx_w] = ctx;
		if (n == 0) begin
			w[comm_root_bit] = 1'b1;
			w[comm_child_lsb +: n_dir] = 3'b111;
		end else begin
			w[comm_up_bit] = 1'b1;
		end
		return w;
	endfunction

	function automatic logic [flit_w-1:0] make_flit(input logic [op_w-1:0] op,
		input logic [ctx_w-1:0] ctx, input logic [seq_w-1:0] sq, input logic [DATA_W-1:0] data);
		logic [flit_w-1:0] f;
		f = '0;
		f[flit_valid_bit] = 1'b1;
		f[flit_op_lsb +: op_w] = op;
		f[flit_ctx_lsb +: ctx_w] = ctx;
		f[flit_seq_lsb +: seq_w] = sq;
		f[flit_data_lsb +: DATA_W] = data;
		return f;
	endfunction

	// New config held as a level through and after reset
	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		for (int n = 0; n < n_node; n++) begin
			newcomm[n] = make_comm(t_ctx[n], n);
			reduce_me[n] = '0;
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// No strobes expected, injection ports held idle
	task automatic watch_quiet(input int cycles, input string what);
		logic rv_bad;
		logic err_bad;
		rv_bad = 1'b0;
		err_bad = 1'b0;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			#1;
			for (int n = 0; n < n_node; n++)
				reduce_me[n] = '0;
			@(negedge clk);
			for (int n = 0; n < n_node; n++) begin
				if (result_valid[n] && !rv_bad) begin
					$display("%s: node %s pulsed result_valid %s", test_name, node_name(n), what);
					rv_bad = 1'b1;
					test_errs++;
				end
			end
			if (ctx_err && !err_bad) begin
				$display("%s: ctx_err pulsed %s", test_name, what);
				err_bad = 1'b1;
				test_errs++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One collective
	////////////////////////////////////////////////////////////////////////////

	task automatic run_collective();
		logic [flit_w-1:0] flit [n_node];
		logic seen [n_node];
		logic [DATA_W-1:0] got [n_node];
		logic err_seen;
		logic finished;
		int max_skew;
		int t;
		max_skew = 0;
		for (int n = 0; n < n_node; n++) begin
			if (t_skew[n] == 8'hff)
				draw_skew(t_skew[n]);
			if (int'(t_skew[n]) > max_skew)
				max_skew = int'(t_skew[n]);
			flit[n] = make_flit(t_op, t_ctx[n], seq, t_data[n]);
			seen[n] = 1'b0;
			got[n] = '0;
		end
		err_seen = 1'b0;
		finished = 1'b0;
		t = 0;
		// Inject on each node's skew cycle, collect until all expected strobes seen
		while (!finished && t < result_timeout) begin
			@(posedge clk);
			#1;
			for (int n = 0; n < n_node; n++)
				reduce_me[n] = (t == int'(t_skew[n])) ? flit[n] : '0;
			@(negedge clk);
			for (int n = 0; n < n_node; n++) begin
				if (result_valid[n]) begin
					if (!t_mask[n]) begin
						$display("%s: node %s delivered a result it should not have",
							test_name, node_name(n));
						test_errs++;
					end else if (seen[n]) begin
						$display("%s: node %s delivered twice", test_name, node_name(n));
						test_errs++;
					end else begin
						seen[n] = 1'b1;
						got[n] = result[n];
					end
				end
			end
			if (ctx_err) begin
				if (t_err == 4'd0) begin
					$display("%s: unexpected ctx_err pulse", test_name);
					test_errs++;
				end
				err_seen = 1'b1;
			end
			finished = (t >= max_skew) && (t_err == 4'd0 || err_seen);
			for (int n = 0; n < n_node; n++) begin
				if (t_mask[n] && !seen[n])
					finished = 1'b0;
			end
			t++;
		end
		if (!finished) begin
			$display("%s: timed out after %0d cycles waiting for result_valid or ctx_err",
				test_name, result_timeout);
			test_errs++;
		end
		for (int n = 0; n < n_node; n++) begin
			if (t_mask[n] && seen[n] && got[n] != t_exp[n]) begin
				$display("ERROR %s node %s: expected %h, actual %h",
					test_name, node_name(n), t_exp[n], got[n]);
				test_errs++;
			end
		end
	endtask

	task automatic run_one();
		test_errs = 0;
		n_run++;
		seq = seq + 8'd1;
		apply_reset();
		// Opcode 0 lines only check a freshly reset network
		if (t_op == 4'd0) begin
			watch_quiet(quiet_cycles, "after reset");
		end else begin
			watch_quiet(settle_cycles, "before injection");
			run_collective();
			watch_quiet(quiet_cycles, "after the collective");
		end
		if (test_errs == 0) begin
			n_pass++;
			$display("%s: PASS", test_name);
		end else begin
			n_fail++;
			$display("%s: FAIL with %0d errors", test_name, test_errs);
		end
	endtask

	initial begin
		logic [8*256-1:0] line;
		logic [8*32-1:0] name_raw;
		int fd;
		int n_fields;
		clk = 1'b0;
		rst_n = 1'b0;
		for (int n = 0; n < n_node; n++) begin
			newcomm[n] = '0;
			reduce_me[n] = '0;
		end
		lfsr = 32'h5420e265;
		seq = '0;
		n_run = 0;
		n_pass = 0;
		n_fail = 0;
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", stim_path);
			$display("Regression failed");
			$finish;
		end else begin
			line = '0;
			while ($fgets(line, fd) != 0) begin
				// Comment lines match fewer fields and are skipped
				n_fields = $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name_raw, t_op, t_ctx[0], t_ctx[1], t_ctx[2], t_ctx[3],
					t_skew[0], t_skew[1], t_skew[2], t_skew[3],
					t_data[0], t_data[1], t_data[2], t_data[3], t_mask, t_err,
					t_exp[0], t_exp[1], t_exp[2], t_exp[3]);
				if (n_fields == 20) begin
					test_name = string'(name_raw);
					run_one();
				end
				line = '0;
			end
			$fclose(fd);
			$display("%0d tests run, %0d passed, %0d failed", n_run, n_pass, n_fail);
			if (n_fail == 0 && n_run > 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

endmodule

/* tb/network_assert.sv */
`timescale 1ns/100ps

// Protocol properties of one node, bound into every node instance
module network_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       result_valid,
	input logic       ctx_err,
	input logic [3:0] link_valid
);

	// Result strobe lasts a single cycle
	result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid)
		else $error("result_valid high for more than one cycle");

	// Registered link outputs cleared by the synchronous reset
	link_reset: assert property (@(posedge clk)
		!rst_n |=> (link_valid == 4'b0000))
		else $error("link valid still high after a reset cycle");

	// A dropped flit never lands on a delivery cycle
	err_vs_result: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctx_err && result_valid))
		else $error("ctx_err and result_valid high in the same cycle");

endmodule

/* rtl/network.sv */
`timescale 1ns/100ps

module network #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm_0_0_0,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm_0_0_1,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm_0_1_0,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm_1_0_0,
	input  logic [mpi_pkg::flit_w-1:0]    reduce_me_0_0_0,
	input  logic [mpi_pkg::flit_w-1:0]    reduce_me_0_0_1,
	input  logic [mpi_pkg::flit_w-1:0]    reduce_me_0_1_0,
	input  logic [mpi_pkg::flit_w-1:0]    reduce_me_1_0_0,
	output logic [DATA_W-1:0]             result_0_0_0,
	output logic [DATA_W-1:0]             result_0_0_1,
	output logic [DATA_W-1:0]             result_0_1_0,
	output logic [DATA_W-1:0]             result_1_0_0,
	output logic                          result_valid_0_0_0,
	output logic                          result_valid_0_0_1,
	output logic                          result_valid_0_1_0,
	output logic                          result_valid_1_0_0,
	output logic                          ctx_err
);
	import mpi_pkg::*;

	// Six real links, child to hub and hub to child per direction
	link_if #(.DATA_W(DATA_W)) up_l [n_dir] ();
	link_if #(.DATA_W(DATA_W)) down_l [n_dir] ();
	// Quiet inputs and dummy sinks for missing links
	link_if #(.DATA_W(DATA_W)) idle_l [n_dir] ();
	link_if #(.DATA_W(DATA_W)) hub_par_sink ();

	logic [comm_w-1:0] leaf_comm [n_dir];
	logic [flit_w-1:0] leaf_flit [n_dir];
	logic [DATA_W-1:0] leaf_result [n_dir];
	logic leaf_result_valid [n_dir];
	logic [n_dir-1:0] leaf_err;
	logic hub_err;

	for (genvar d = 0; d < n_dir; d++) begin : g_idle
		assign idle_l[d].valid = 1'b0;
		assign idle_l[d].opcode = '0;
		assign idle_l[d].contextid = '0;
		assign idle_l[d].seq = '0;
		assign idle_l[d].data = '0;
	end

	// Leaf 0_0_1 on x, 0_1_0 on y, 1_0_0 on z
	assign leaf_comm[dir_x] = newcomm_0_0_1;
	assign leaf_comm[dir_y] = newcomm_0_1_0;
	assign leaf_comm[dir_z] = newcomm_1_0_0;
	assign leaf_flit[dir_x] = reduce_me_0_0_1;
	assign leaf_flit[dir_y] = reduce_me_0_1_0;
	assign leaf_flit[dir_z] = reduce_me_1_0_0;
	assign result_0_0_1 = leaf_result[dir_x];
	assign result_0_1_0 = leaf_result[dir_y];
	assign result_1_0_0 = leaf_result[dir_z];
	assign result_valid_0_0_1 = leaf_result_valid[dir_x];
	assign result_valid_0_1_0 = leaf_result_valid[dir_y];
	assign result_valid_1_0_0 = leaf_result_valid[dir_z];

	assign ctx_err = hub_err | (|leaf_err);

	// Hub, no parent
	node #(
		.DATA_W(DATA_W)
	) node_0_0_0 (
		.clk(clk),
		.rst_n(rst_n),
		.newcomm(newcomm_0_0_0),
		.reduce_me(reduce_me_0_0_0),
		.xyz_up_in(up_l),
		.xyz_down_out(down_l),
		.par_up_out(hub_par_sink),
		.par_down_in(idle_l[dir_x]),
		.result(result_0_0_0),
		.result_valid(result_valid_0_0_0),
		.ctx_err(hub_err)
	);

	for (genvar d = 0; d < n_dir; d++) begin : g_leaf
		// Leaf has no children of its own
		link_if #(.DATA_W(DATA_W)) sink [n_dir] ();

		node #(
			.DATA_W(DATA_W)
		) leaf_node (
			.clk(clk),
			.rst_n(rst_n),
			.newcomm(leaf_comm[d]),
			.reduce_me(leaf_flit[d]),
			.xyz_up_in(idle_l),
			.xyz_down_out(sink),
			.par_up_out(up_l[d]),
			.par_down_in(down_l[d]),
			.result(leaf_result[d]),
			.result_valid(leaf_result_valid[d]),
			.ctx_err(leaf_err[d])
		);
	end

endmodule

/* rtl/node.sv */
`timescale 1ns/100ps

module node #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm,
	input  logic [mpi_pkg::flit_w-1:0]    reduce_me,
	link_if.rx                            xyz_up_in [mpi_pkg::n_dir],
	link_if.tx                            xyz_down_out [mpi_pkg::n_dir],
	link_if.tx                            par_up_out,
	link_if.rx                            par_down_in,
	output logic [DATA_W-1:0]             result,
	output logic                          result_valid,
	output logic                          ctx_err
);
	import mpi_pkg::*;

	// Output slots, children first then parent
	localparam int n_out = n_dir + 1;
	localparam int par_slot = n_dir;

	logic [n_dir-1:0] children;

	// Engine side of the links
	link_if #(.DATA_W(DATA_W)) kid_in [n_dir] ();
	link_if #(.DATA_W(DATA_W)) kid_out [n_dir] ();
	link_if #(.DATA_W(DATA_W)) par_out ();

	logic nxt_valid [n_out];
	logic [op_w-1:0] nxt_op [n_out];
	logic [ctx_w-1:0] nxt_ctx [n_out];
	logic [seq_w-1:0] nxt_seq [n_out];
	logic [DATA_W-1:0] nxt_data [n_out];
	logic q_valid [n_out];
	logic [op_w-1:0] q_op [n_out];
	logic [ctx_w-1:0] q_ctx [n_out];
	logic [seq_w-1:0] q_seq [n_out];
	logic [DATA_W-1:0] q_data [n_out];

	for (genvar d = 0; d < n_dir; d++) begin : g_dir
		// Stray strobes from non-members ignored
		assign kid_in[d].valid = xyz_up_in[d].valid & children[d];
		assign kid_in[d].opcode = xyz_up_in[d].opcode;
		assign kid_in[d].contextid = xyz_up_in[d].contextid;
		assign kid_in[d].seq = xyz_up_in[d].seq;
		assign kid_in[d].data = xyz_up_in[d].data;

		assign nxt_valid[d] = kid_out[d].valid;
		assign nxt_op[d] = kid_out[d].opcode;
		assign nxt_ctx[d] = kid_out[d].contextid;
		assign nxt_seq[d] = kid_out[d].seq;
		assign nxt_data[d] = kid_out[d].data;

		assign xyz_down_out[d].valid = q_valid[d];
		assign xyz_down_out[d].opcode = q_op[d];
		assign xyz_down_out[d].contextid = q_ctx[d];
		assign xyz_down_out[d].seq = q_seq[d];
		assign xyz_down_out[d].data = q_data[d];
	end

	assign nxt_valid[par_slot] = par_out.valid;
	assign nxt_op[par_slot] = par_out.opcode;
	assign nxt_ctx[par_slot] = par_out.contextid;
	assign nxt_seq[par_slot] = par_out.seq;
	assign nxt_data[par_slot] = par_out.data;

	assign par_up_out.valid = q_valid[par_slot];
	assign par_up_out.opcode = q_op[par_slot];
	assign par_up_out.contextid = q_ctx[par_slot];
	assign par_up_out.seq = q_seq[par_slot];
	assign par_up_out.data = q_data[par_slot];

	////////////////////////////////////////////////////////////////////////////
	// Output flops, one cycle per hop
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_out; i++) begin
			if (!rst_n)
				q_valid[i] <= 1'b0;
			else
				q_valid[i] <= nxt_valid[i];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_out; i++) begin
			q_op[i] <= nxt_op[i];
			q_ctx[i] <= nxt_ctx[i];
			q_seq[i] <= nxt_seq[i];
			q_data[i] <= nxt_data[i];
		end
	end

	reduce_unit #(
		.DATA_W(DATA_W)
	) reduce_unit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.newcomm(newcomm),
		.local_flit(reduce_me),
		.up_in(kid_in),
		.down_in(par_down_in),
		.up_out(par_out),
		.down_out(kid_out),
		.children(children),
		.result(result),
		.result_valid(result_valid),
		.ctx_err(ctx_err)
	);

endmodule

/* rtl/reduce_unit.sv */
`timescale 1ns/100ps

module reduce_unit #(
	parameter int DATA_W = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [mpi_pkg::comm_w-1:0]    newcomm,
	input  logic [mpi_pkg::flit_w-1:0]    local_flit,
	link_if.rx                            up_in [mpi_pkg::n_dir],
	link_if.rx                            down_in,
	link_if.tx                            up_out,
	link_if.tx                            down_out [mpi_pkg::n_dir],
	output logic [mpi_pkg::n_dir-1:0]     children,
	output logic [DATA_W-1:0]             result,
	output logic                          result_valid,
	output logic                          ctx_err
);
	import mpi_pkg::*;

	// Source 0 local, 1..3 children x y z, last one the parent
	localparam int n_src = n_dir + 1;
	localparam int n_chk = n_src + 1;
	localparam int down_idx = n_src;

	logic src_valid [n_chk];
	logic [op_w-1:0] src_op [n_chk];
	logic [n_chk-1:0][ctx_w-1:0] src_ctx;
	logic [seq_w-1:0] src_seq [n_chk];
	logic [DATA_W-1:0] src_data [n_chk];
	logic [n_chk-1:0] ctx_ok;

	logic is_root;
	logic has_parent;
	logic [cnt_w-1:0] expected;

	// Open operation
	logic busy;
	logic wait_down;
	logic [op_w-1:0] cur_op;
	logic [ctx_w-1:0] cur_ctx;
	logic [seq_w-1:0] cur_seq;
	logic [DATA_W-1:0] cur_sum;
	logic [cnt_w-1:0] cur_cnt;

	logic [op_w-1:0] key_op;
	logic [ctx_w-1:0] key_ctx;
	logic [seq_w-1:0] key_seq;
	logic [n_src-1:0] take;
	logic [DATA_W-1:0] acc_sum;
	logic [cnt_w-1:0] acc_cnt;
	logic done;
	logic down_take;
	logic err_now;
	logic fan_valid;
	logic [DATA_W-1:0] fan_data;

	assign src_valid[0] = local_flit[flit_valid_bit];
	assign src_op[0] = local_flit[flit_op_lsb +: op_w];
	assign src_ctx[0] = local_flit[flit_ctx_lsb +: ctx_w];
	assign src_seq[0] = local_flit[flit_seq_lsb +: seq_w];
	assign src_data[0] = local_flit[flit_data_lsb +: DATA_W];

	for (genvar d = 0; d < n_dir; d++) begin : g_dir
		assign src_valid[d+1] = up_in[d].valid;
		assign src_op[d+1] = up_in[d].opcode;
		assign src_ctx[d+1] = up_in[d].contextid;
		assign src_seq[d+1] = up_in[d].seq;
		assign src_data[d+1] = up_in[d].data;
		// Fan-out only on member children
		assign down_out[d].valid = fan_valid & children[d];
		assign down_out[d].opcode = key_op;
		assign down_out[d].contextid = key_ctx;
		assign down_out[d].seq = key_seq;
		assign down_out[d].data = fan_data;
	end

	assign src_valid[down_idx] = down_in.valid;
	assign src_op[down_idx] = down_in.opcode;
	assign src_ctx[down_idx] = down_in.contextid;
	assign src_seq[down_idx] = down_in.seq;
	assign src_data[down_idx] = down_in.data;

	comm_table #(
		.N_CHK(n_chk)
	) comm_table_inst (
		.clk(clk),
		.rst_n(rst_n),
		.newcomm(newcomm),
		.contextid(src_ctx),
		.ctx_ok(ctx_ok),
		.root(is_root),
		.children(children),
		.has_parent(has_parent),
		.expected(expected)
	);

	////////////////////////////////////////////////////////////////////////////
	// Gather and sum
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Open op wins, else lowest good source opens a new one
		key_op = cur_op;
		key_ctx = cur_ctx;
		key_seq = cur_seq;
		for (int i = n_src - 1; i >= 0; i--) begin
			if (!busy && !wait_down && src_valid[i] && ctx_ok[i]) begin
				key_op = src_op[i];
				key_ctx = src_ctx[i];
				key_seq = src_seq[i];
			end
		end

		acc_sum = busy ? cur_sum : '0;
		acc_cnt = busy ? cur_cnt : '0;
		err_now = 1'b0;
		for (int i = 0; i < n_src; i++) begin
			take[i] = src_valid[i] && ctx_ok[i] && !wait_down
				&& (src_seq[i] == key_seq) && (src_op[i] == key_op);
			if (take[i]) begin
				acc_cnt = acc_cnt + cnt_w'(1);
				// Bcast keeps the root's own word only
				if (key_op != op_short_bcast || (i == 0 && is_root))
					acc_sum = acc_sum + src_data[i];
			end else if (src_valid[i]) begin
				err_now = 1'b1;
			end
		end
		done = (|take) && (acc_cnt == expected);

		// Result from the parent for the waiting op
		down_take = src_valid[down_idx] && ctx_ok[down_idx] && wait_down
			&& (src_seq[down_idx] == cur_seq) && (src_op[down_idx] == cur_op);
		if (src_valid[down_idx] && !down_take)
			err_now = 1'b1;

		// Root starts the fan-out, an inner node relays it
		fan_valid = (done && is_root && key_op != op_short_reduce) || down_take;
		fan_data = down_take ? src_data[down_idx] : acc_sum;
	end

	// Partial sum towards the parent
	assign up_out.valid = done && has_parent;
	assign up_out.opcode = key_op;
	assign up_out.contextid = key_ctx;
	assign up_out.seq = key_seq;
	assign up_out.data = acc_sum;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			wait_down <= 1'b0;
			cur_cnt <= '0;
			result_valid <= 1'b0;
			ctx_err <= 1'b0;
		end else begin
			result_valid <= (done && is_root) || down_take;
			ctx_err <= err_now;
			cur_cnt <= acc_cnt;
			if (done) begin
				busy <= 1'b0;
				wait_down <= has_parent && (key_op != op_short_reduce);
			end else if (|take) begin
				busy <= 1'b1;
			end
			if (down_take)
				wait_down <= 1'b0;
		end
	end

	// Operation payload and delivered word
	always_ff @(posedge clk) begin
		if (|take) begin
			cur_op <= key_op;
			cur_ctx <= key_ctx;
			cur_seq <= key_seq;
			cur_sum <= acc_sum;
		end
		if (done && is_root)
			result <= acc_sum;
		else if (down_take)
			result <= src_data[down_idx];
	end

endmodule

/* rtl/comm_table.sv */
`timescale 1ns/100ps

module comm_table #(
	parameter int N_CHK = 1
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [mpi_pkg::comm_w-1:0]             newcomm,
	input  logic [N_CHK-1:0][mpi_pkg::ctx_w-1:0]   contextid,
	output logic [N_CHK-1:0]                       ctx_ok,
	output logic                                   root,
	output logic [mpi_pkg::n_dir-1:0]              children,
	output logic                                   has_parent,
	output logic [mpi_pkg::cnt_w-1:0]              expected
);
	import mpi_pkg::*;

	// Stored communicator
	logic cfg_valid;
	logic [ctx_w-1:0] cfg_ctx;
	logic cfg_root;
	logic [n_dir-1:0] cfg_child;
	logic cfg_up;

	// Latch on every valid newcomm, held until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_valid <= 1'b0;
			cfg_ctx <= '0;
			cfg_root <= 1'b0;
			cfg_child <= '0;
			cfg_up <= 1'b0;
		end else if (newcomm[comm_valid_bit]) begin
			cfg_valid <= 1'b1;
			cfg_ctx <= newcomm[comm_ctx_lsb +: ctx_w];
			cfg_root <= newcomm[comm_root_bit];
			cfg_child <= newcomm[comm_child_lsb +: n_dir];
			cfg_up <= newcomm[comm_up_bit];
		end
	end

	// One compare per flit source
	always_comb begin
		for (int i = 0; i < N_CHK; i++) begin
			ctx_ok[i] = cfg_valid && (contextid[i] == cfg_ctx);
		end
	end

	assign root = cfg_root;
	assign children = cfg_child;
	assign has_parent = cfg_up;

	// Children plus own flit
	assign expected = cnt_w'($countones(cfg_child)) + cnt_w'(1);

endmodule

/* rtl/link_if.sv */
`timescale 1ns/100ps

// One direction of one node-to-node link
// No handshake, the receiver takes the flit in its valid cycle
interface link_if #(
	parameter int DATA_W = 32
);
	import mpi_pkg::*;

	logic valid;
	logic [op_w-1:0] opcode;
	logic [ctx_w-1:0] contextid;
	logic [seq_w-1:0] seq;
	logic [DATA_W-1:0] data;

	// Sending node
	modport tx (output valid, opcode, contextid, seq, data);

	// Receiving node
	modport rx (input valid, opcode, contextid, seq, data);

endinterface

/* rtl/mpi_pkg.sv */
package mpi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int op_w = 4;
	localparam int ctx_w = 8;
	localparam int seq_w = 8;
	localparam int flit_data_w = 32;
	// Link directions below the hub
	localparam int n_dir = 3;
	// Arrival counter, up to all children plus the local flit
	localparam int cnt_w = 3;

	// Collective opcodes
	localparam logic [op_w-1:0] op_short_bcast = 4'b0111;
	localparam logic [op_w-1:0] op_short_reduce = 4'b1100;
	localparam logic [op_w-1:0] op_short_allreduce = 4'b1110;

	////////////////////////////////////////////////////////////////////////////
	// Injected flit, top down: valid, opcode, contextid, seq, data
	////////////////////////////////////////////////////////////////////////////

	localparam int flit_w = 1 + op_w + ctx_w + seq_w + flit_data_w;
	localparam int flit_data_lsb = 0;
	localparam int flit_seq_lsb = flit_data_lsb + flit_data_w;
	localparam int flit_ctx_lsb = flit_seq_lsb + seq_w;
	localparam int flit_op_lsb = flit_ctx_lsb + ctx_w;
	localparam int flit_valid_bit = flit_op_lsb + op_w;

	////////////////////////////////////////////////////////////////////////////
	// Newcomm word, top down: valid, contextid, is_root, children, uplink
	////////////////////////////////////////////////////////////////////////////

	localparam int comm_up_bit = 0;
	localparam int comm_child_lsb = comm_up_bit + 1;
	localparam int comm_root_bit = comm_child_lsb + n_dir;
	localparam int comm_ctx_lsb = comm_root_bit + 1;
	localparam int comm_valid_bit = comm_ctx_lsb + ctx_w;
	localparam int comm_w = comm_valid_bit + 1;

	// Bit of each direction in the children mask
	localparam logic [1:0] dir_x = 2'd0;
	localparam logic [1:0] dir_y = 2'd1;
	localparam logic [1:0] dir_z = 2'd2;

endpackage
